// ==== swa_stimulus.txt ====
# inputs: name ivc_request ovc_is_assigned assigned_ovc_not_full valid_speculation dest_port
# expect: ivc_granted granted_dest_port spec_granted_dest_port any_ivc_granted spec_first_arb_ivc

# port 0 rotates through its vcs
t1_rr_vc0        0000f 0000f fffff 00 28142418842214221111 00001 00001 00000 01 00000
t1_rr_vc1        0000f 0000f fffff 00 28142418842214221111 00002 00001 00000 01 00000
t1_rr_vc2        0000f 0000f fffff 00 28142418842214221111 00004 00001 00000 01 00000
t1_rr_vc3        0000f 0000f fffff 00 28142418842214221111 00008 00001 00000 01 00000

# ports 0 and 2 both want output 3
t2_out_first     00c01 00c01 fffff 00 28142418842214221114 00001 00004 00000 01 00000
t2_out_second    00c01 00c01 fffff 00 28142418842214221114 00400 00400 00000 04 00000

# port 4 vc1 has no room
t3_full_a        70000 70000 dffff 00 28142418842214221111 10000 40000 00000 10 00000
t3_full_b        70000 70000 dffff 00 28142418842214221111 40000 80000 00000 10 00000
t3_full_c        70000 70000 dffff 00 28142418842214221111 10000 40000 00000 10 00000

# spec grants hit a busy input and a busy output
t4_spec_conflict 01850 00810 fffff 1f 28142418842214221111 00810 00820 00000 06 01040

# unopposed spec grant, valid then invalid then valid
t5_spec_valid    00003 00000 fffff 01 28142418842214221111 00001 00001 00001 01 00001
t5_spec_invalid  00003 00000 fffff 00 28142418842214221111 00000 00000 00000 00 00002
t5_spec_again    00003 00000 fffff 01 28142418842214221111 00001 00001 00001 01 00001

# nonspec and spec side by side
t6_mixed         24000 04000 fffff 1f 28142418842214221111 24000 14000 10000 18 20000

// ==== all.f ====
+incdir+.
noc_pkg.sv
swa_pkg.sv
swa_result_if.sv
rr_arbiter.sv
sw_alloc_stage.sv
spec_merge_ctrl.sv
spec_sw_alloc.sv
tb_spec_sw_alloc.sv

// ==== Makefile ====
.PHONY: all run lint clean

all: run

obj_dir/Vtb_spec_sw_alloc: all.f $(wildcard *.sv *.svh)
	verilator --binary --timing --top-module tb_spec_sw_alloc -f all.f

run: obj_dir/Vtb_spec_sw_alloc
	./obj_dir/Vtb_spec_sw_alloc

lint:
	verilator --lint-only --timing -Wall --top-module spec_sw_alloc -f all.f

clean:
	rm -rf obj_dir

// ==== tb_spec_sw_alloc.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "swa_defines.svh"

module tb_spec_sw_alloc;

    localparam int CLK_PERIOD = 10;
    localparam int VC_W       = `SWA_P * `SWA_V;
    localparam int SEL_W      = `SWA_P * (`SWA_P - 1);
    localparam int DEST_W     = `SWA_P * `SWA_V * (`SWA_P - 1);

    logic              clk;
    logic              rst_n;
    logic [VC_W-1:0]   ivc_request;
    logic [VC_W-1:0]   ovc_is_assigned;
    logic [VC_W-1:0]   assigned_ovc_not_full;
    logic [`SWA_P-1:0] valid_speculation;
    logic [DEST_W-1:0] dest_port;
    logic [VC_W-1:0]   ivc_granted;
    logic [SEL_W-1:0]  granted_dest_port;
    logic [SEL_W-1:0]  nonspec_granted_dest_port;
    logic [SEL_W-1:0]  spec_granted_dest_port;
    logic [VC_W-1:0]   spec_first_arb_ivc;
    logic [`SWA_P-1:0] any_ivc_granted;

    // one entry per test line of the stimulus file
    logic [8*16-1:0]   name_q [$];
    logic [VC_W-1:0]   req_q [$];
    logic [VC_W-1:0]   asg_q [$];
    logic [VC_W-1:0]   room_q [$];
    logic [`SWA_P-1:0] vspec_q [$];
    logic [DEST_W-1:0] dest_q [$];
    logic [VC_W-1:0]   exp_ivc_q [$];
    logic [SEL_W-1:0]  exp_dest_q [$];
    logic [SEL_W-1:0]  exp_spec_q [$];
    logic [`SWA_P-1:0] exp_any_q [$];
    logic [VC_W-1:0]   exp_first_q [$];

    // watchdog starts once the test count is known
    logic loaded;

    spec_sw_alloc uut (
        .clk                      (clk),
        .rst_n                    (rst_n),
        .ivc_request              (ivc_request),
        .ovc_is_assigned          (ovc_is_assigned),
        .assigned_ovc_not_full    (assigned_ovc_not_full),
        .valid_speculation        (valid_speculation),
        .dest_port                (dest_port),
        .ivc_granted              (ivc_granted),
        .granted_dest_port        (granted_dest_port),
        .nonspec_granted_dest_port(nonspec_granted_dest_port),
        .spec_granted_dest_port   (spec_granted_dest_port),
        .spec_first_arb_ivc       (spec_first_arb_ivc),
        .any_ivc_granted          (any_ivc_granted)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // one cycle per test with margin for reset and the idle cycle
    initial begin
        wait (loaded);
        #((name_q.size() + 10) * CLK_PERIOD);
        $display("Simulation FAILED");
        $fatal(1, "watchdog expired before all tests were applied");
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %0s expected %h actual %h", name, expected, actual);
            $display("Simulation FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic load_stimulus();
        int                fd;
        int                n;
        string             line;
        logic [8*16-1:0]   t_name;
        logic [VC_W-1:0]   t_req;
        logic [VC_W-1:0]   t_asg;
        logic [VC_W-1:0]   t_room;
        logic [`SWA_P-1:0] t_vspec;
        logic [DEST_W-1:0] t_dest;
        logic [VC_W-1:0]   t_ivc;
        logic [SEL_W-1:0]  t_gdest;
        logic [SEL_W-1:0]  t_sdest;
        logic [`SWA_P-1:0] t_any;
        logic [VC_W-1:0]   t_first;
        fd = $fopen("swa_stimulus.txt", "r");
        if (fd == 0) begin
            $display("Simulation FAILED");
            $fatal(1, "could not open swa_stimulus.txt in the project root");
        end
        while ($fgets(line, fd) != 0) begin
            // skip comments and blank lines
            if (line.len() >= 2 && line.getc(0) != "#") begin
                n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", t_name, t_req, t_asg,
                            t_room, t_vspec, t_dest, t_ivc, t_gdest, t_sdest, t_any, t_first);
                if (n != 11) begin
                    $display("Simulation FAILED");
                    $fatal(1, "stimulus line has the wrong number of fields: %s", line);
                end
                name_q.push_back(t_name);
                req_q.push_back(t_req);
                asg_q.push_back(t_asg);
                room_q.push_back(t_room);
                vspec_q.push_back(t_vspec);
                dest_q.push_back(t_dest);
                exp_ivc_q.push_back(t_ivc);
                exp_dest_q.push_back(t_gdest);
                exp_spec_q.push_back(t_sdest);
                exp_any_q.push_back(t_any);
                exp_first_q.push_back(t_first);
            end
        end
        $fclose(fd);
        if (name_q.size() == 0) begin
            $display("Simulation FAILED");
            $fatal(1, "the stimulus file holds no test lines");
        end
    endtask

    task automatic apply_inputs(input int k);
        ivc_request           = req_q[k];
        ovc_is_assigned       = asg_q[k];
        assigned_ovc_not_full = room_q[k];
        valid_speculation     = vspec_q[k];
        dest_port             = dest_q[k];
    endtask

    task automatic compare_outputs(input int k);
        check_value($sformatf("%0s ivc_granted", name_q[k]),
                    32'(exp_ivc_q[k]), 32'(ivc_granted));
        check_value($sformatf("%0s granted_dest_port", name_q[k]),
                    32'(exp_dest_q[k]), 32'(granted_dest_port));
        check_value($sformatf("%0s spec_granted_dest_port", name_q[k]),
                    32'(exp_spec_q[k]), 32'(spec_granted_dest_port));
        // a port holds one grant kind, so nonspec is the merged grant minus the kept spec
        check_value($sformatf("%0s nonspec_granted_dest_port", name_q[k]),
                    32'(exp_dest_q[k] & ~exp_spec_q[k]), 32'(nonspec_granted_dest_port));
        check_value($sformatf("%0s any_ivc_granted", name_q[k]),
                    32'(exp_any_q[k]), 32'(any_ivc_granted));
        check_value($sformatf("%0s spec_first_arb_ivc", name_q[k]),
                    32'(exp_first_q[k]), 32'(spec_first_arb_ivc));
    endtask

    initial begin
        loaded                = 1'b0;
        rst_n                 = 1'b0;
        ivc_request           = '0;
        ovc_is_assigned       = '0;
        assigned_ovc_not_full = '0;
        valid_speculation     = '0;
        dest_port             = '0;
        load_stimulus();
        loaded = 1'b1;
        // reset over 4 rising edges, released on a falling edge
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        for (int k = 0; k < name_q.size(); k++) begin
            @(negedge clk);
            apply_inputs(k);
            // grants are combinational, sampled before the rising edge moves the pointers
            #(CLK_PERIOD / 4);
            compare_outputs(k);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== spec_sw_alloc.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "swa_defines.svh"

module spec_sw_alloc (
    input  logic                                  clk,
    input  logic                                  rst_n,
    // per vc, port-major
    input  logic [`SWA_P*`SWA_V-1:0]              ivc_request,
    input  logic [`SWA_P*`SWA_V-1:0]              ovc_is_assigned,
    input  logic [`SWA_P*`SWA_V-1:0]              assigned_ovc_not_full,
    // per port, from the vc allocator
    input  logic [`SWA_P-1:0]                     valid_speculation,
    // own-port-excluded select per vc
    input  logic [`SWA_P*`SWA_V*(`SWA_P-1)-1:0]   dest_port,
    output logic [`SWA_P*`SWA_V-1:0]              ivc_granted,
    output logic [`SWA_P*(`SWA_P-1)-1:0]          granted_dest_port,
    output logic [`SWA_P*(`SWA_P-1)-1:0]          nonspec_granted_dest_port,
    output logic [`SWA_P*(`SWA_P-1)-1:0]          spec_granted_dest_port,
    output logic [`SWA_P*`SWA_V-1:0]              spec_first_arb_ivc,
    output logic [`SWA_P-1:0]                     any_ivc_granted
);

    import swa_pkg::*;

    // split requests, one bundle per stage
    swa_req_t nonspec_req;
    swa_req_t spec_req;

    swa_result_if nonspec_res ();
    swa_result_if spec_res ();

    // vcs holding an ovc with room
    sw_alloc_stage u_nonspec_stage (
        .clk  (clk),
        .rst_n(rst_n),
        .req  (nonspec_req),
        .dest (dest_port),
        .res  (nonspec_res.stage)
    );

    // vcs still waiting for an ovc, runs in parallel
    sw_alloc_stage u_spec_stage (
        .clk  (clk),
        .rst_n(rst_n),
        .req  (spec_req),
        .dest (dest_port),
        .res  (spec_res.stage)
    );

    spec_merge_ctrl u_merge (
        .ivc_request          (ivc_request),
        .ovc_is_assigned      (ovc_is_assigned),
        .assigned_ovc_not_full(assigned_ovc_not_full),
        .valid_speculation    (valid_speculation),
        .nonspec_req          (nonspec_req),
        .spec_req             (spec_req),
        .nonspec              (nonspec_res.merge),
        .spec                 (spec_res.merge),
        .ivc_granted          (ivc_granted),
        .granted_dest         (granted_dest_port),
        .nonspec_granted_dest (nonspec_granted_dest_port),
        .spec_granted_dest    (spec_granted_dest_port),
        .spec_first_arb_ivc   (spec_first_arb_ivc),
        .any_ivc_granted      (any_ivc_granted)
    );

endmodule

`default_nettype wire

// ==== spec_merge_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "swa_defines.svh"

module spec_merge_ctrl (
    input  noc_pkg::vc_mask_arr_t     ivc_request,
    input  noc_pkg::vc_mask_arr_t     ovc_is_assigned,
    input  noc_pkg::vc_mask_arr_t     assigned_ovc_not_full,
    input  noc_pkg::port_mask_t       valid_speculation,
    output swa_pkg::swa_req_t         nonspec_req,
    output swa_pkg::swa_req_t         spec_req,
    swa_result_if.merge               nonspec,
    swa_result_if.merge               spec,
    output noc_pkg::vc_mask_arr_t     ivc_granted,
    output noc_pkg::outport_sel_arr_t granted_dest,
    output noc_pkg::outport_sel_arr_t nonspec_granted_dest,
    output noc_pkg::outport_sel_arr_t spec_granted_dest,
    output noc_pkg::vc_mask_arr_t     spec_first_arb_ivc,
    output noc_pkg::port_mask_t       any_ivc_granted
);

    import noc_pkg::*;

    // destinations still open to a speculative grant
    outport_sel_arr_t accept_sel;
    port_mask_t       keep;
    outport_sel_arr_t spec_dest_kept;
    vc_mask_arr_t     spec_ivc_kept;
    // output ports taken by kept speculative grants
    port_mask_t       kept_out;

    // non-speculative needs an assigned ovc with room
    assign nonspec_req.vc_req = ivc_request & ovc_is_assigned & assigned_ovc_not_full;
    // speculative covers vcs still waiting for an ovc
    assign spec_req.vc_req = ivc_request & ~ovc_is_assigned;

    always_comb begin
        kept_out = '0;
        for (int i = 0; i < `SWA_P; i++) begin
            // nothing open once the input port is busy
            // otherwise every output not taken by the nonspec stage
            accept_sel[i] = nonspec.inport_granted[i] ? '0
                          : ~port_to_sel(i, nonspec.outport_granted);
            // vc allocator must also confirm the speculation
            keep[i] = valid_speculation[i] & spec.inport_granted[i]
                    & (|(accept_sel[i] & spec.granted_dest[i]));
            spec_dest_kept[i] = keep[i] ? spec.granted_dest[i] : '0;
            spec_ivc_kept[i]  = keep[i] ? spec.ivc_granted[i] : '0;
            kept_out = kept_out | sel_to_port(i, spec_dest_kept[i]);
        end
    end

    // merged grants
    assign ivc_granted          = nonspec.ivc_granted | spec_ivc_kept;
    assign granted_dest         = nonspec.granted_dest | spec_dest_kept;
    assign nonspec_granted_dest = nonspec.granted_dest;
    assign spec_granted_dest    = spec_dest_kept;
    // first choice shown even when the grant is dropped
    assign spec_first_arb_ivc   = spec.first_arb_ivc;
    assign any_ivc_granted      = nonspec.any_ivc_grant | (keep & spec.any_ivc_grant);

    // cross-stage checks on the merged result
    always_comb begin
        for (int i = 0; i < `SWA_P; i++) begin
            assert (!((|nonspec.granted_dest[i]) && (|spec_dest_kept[i])))
                else $error("spec_merge_ctrl: port %0d has both grant kinds", i);
            assert (!((|nonspec.ivc_granted[i]) && (|spec_ivc_kept[i])))
                else $error("spec_merge_ctrl: vc mask %0d has both grant kinds", i);
        end
        // an output carries at most one kind of grant
        assert ((kept_out & nonspec.outport_granted) == '0)
            else $error("spec_merge_ctrl: output shared by both stages %b", kept_out);
    end

endmodule

`default_nettype wire

// ==== sw_alloc_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "swa_defines.svh"

module sw_alloc_stage (
    input  logic                   clk,
    input  logic                   rst_n,
    input  swa_pkg::swa_req_t      req,
    input  noc_pkg::dest_sel_arr_t dest,
    swa_result_if.stage            res
);

    import noc_pkg::*;

    // first stage, one vc per input port
    vc_mask_arr_t     first_gnt;
    port_mask_t       vc_any;
    // destination of the chosen vc
    outport_sel_arr_t vc_dest;
    // same destination as a real output port, per input
    port_mask_t [`SWA_P-1:0] in_port;
    // second stage, requests and grants per output port
    port_mask_t [`SWA_P-1:0] out_req;
    port_mask_t [`SWA_P-1:0] out_gnt;
    port_mask_t       out_any;
    // input ports that won their output
    port_mask_t       in_win;
    vc_mask_arr_t     ivc_win;
    outport_sel_arr_t dest_win;
    port_mask_t       any_win;

    for (genvar i = 0; i < `SWA_P; i++) begin : g_in
        // input arbiter moves only when the port wins at the output
        rr_arbiter #(
            .req_t(vc_mask_t)
        ) u_vc_arb (
            .clk      (clk),
            .rst_n    (rst_n),
            .request  (req.vc_req[i]),
            .grant    (first_gnt[i]),
            .any_grant(vc_any[i]),
            .advance  (in_win[i])
        );

        // a losing port keeps its vc choice while its requests hold
        assert property (@(posedge clk) disable iff (!rst_n)
            $past(vc_any[i] && !in_win[i]) && $stable(req.vc_req[i])
            |-> $stable(first_gnt[i]))
            else $error("sw_alloc_stage: port %0d vc choice moved without a win", i);
    end

    for (genvar o = 0; o < `SWA_P; o++) begin : g_out
        // output arbiter moves whenever it grants
        rr_arbiter #(
            .req_t(port_mask_t)
        ) u_port_arb (
            .clk      (clk),
            .rst_n    (rst_n),
            .request  (out_req[o]),
            .grant    (out_gnt[o]),
            .any_grant(out_any[o]),
            .advance  (out_any[o])
        );
    end

    // pick the destination of the granted vc
    always_comb begin
        for (int i = 0; i < `SWA_P; i++) begin
            vc_dest[i] = '0;
            for (int v = 0; v < `SWA_V; v++) begin
                if (first_gnt[i][v]) begin
                    vc_dest[i] = vc_dest[i] | dest[i][v];
                end
            end
            in_port[i] = vc_any[i] ? sel_to_port(i, vc_dest[i]) : '0;
        end
    end

    // transpose into per-output request masks
    always_comb begin
        for (int o = 0; o < `SWA_P; o++) begin
            for (int i = 0; i < `SWA_P; i++) begin
                out_req[o][i] = in_port[i][o];
            end
        end
    end

    // map output grants back to the input side
    always_comb begin
        for (int i = 0; i < `SWA_P; i++) begin
            in_win[i] = 1'b0;
            for (int o = 0; o < `SWA_P; o++) begin
                in_win[i] = in_win[i] | out_gnt[o][i];
            end
            ivc_win[i]  = in_win[i] ? first_gnt[i] : '0;
            dest_win[i] = in_win[i] ? vc_dest[i] : '0;
            any_win[i]  = |ivc_win[i];
        end
    end

    assign res.ivc_granted     = ivc_win;
    assign res.first_arb_ivc   = first_gnt;
    assign res.granted_dest    = dest_win;
    assign res.inport_granted  = in_win;
    assign res.outport_granted = out_any;
    assign res.any_ivc_grant   = any_win;

endmodule

`default_nettype wire

// ==== rr_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module rr_arbiter #(
    parameter type req_t = noc_pkg::vc_mask_t
) (
    input  logic clk,
    input  logic rst_n,
    input  req_t request,
    output req_t grant,
    output logic any_grant,
    input  logic advance
);

    localparam int N = $bits(req_t);
    // index 0 has top priority out of reset
    localparam logic [N-1:0] PTR_INIT = {{(N-1){1'b0}}, 1'b1};

    logic [N-1:0] req_vec;
    // one-hot priority pointer
    logic [N-1:0] ptr;
    logic [N-1:0] upper_mask;
    logic [N-1:0] upper_req;
    logic [N-1:0] gnt_vec;

    assign req_vec = request;

    // requesters at or above the pointer
    // mask is ptr - 1 inverted
    assign upper_mask = ~(ptr + {N{1'b1}});
    assign upper_req  = req_vec & upper_mask;

    // lowest set bit of the upper part or else the lowest overall
    assign gnt_vec = (|upper_req) ? (upper_req & -upper_req) : (req_vec & -req_vec);

    assign grant     = gnt_vec;
    assign any_grant = |req_vec;

    // next priority goes to the index after the grantee
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ptr <= PTR_INIT;
        end else if (advance && any_grant) begin
            ptr <= {gnt_vec[N-2:0], gnt_vec[N-1]};
        end
    end

    // grant is one-hot or empty and only to a requester
    assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant) && ((grant & ~request) == '0))
        else $error("rr_arbiter: bad grant %b for request %b", grant, request);

endmodule

`default_nettype wire

// ==== swa_result_if.sv ====
`timescale 1ns/100ps
`default_nettype none

// results of one switch allocation stage
interface swa_result_if;

    import noc_pkg::*;

    // vc per input port that won at its output
    vc_mask_arr_t     ivc_granted;
    // input arbiter choice, before output arbitration
    vc_mask_arr_t     first_arb_ivc;
    // winning destination per input port
    outport_sel_arr_t granted_dest;
    // input ports that won an output
    port_mask_t       inport_granted;
    // output ports that granted, by output index
    port_mask_t       outport_granted;
    // any vc of the port granted
    port_mask_t       any_ivc_grant;

    modport stage (
        output ivc_granted,
        output first_arb_ivc,
        output granted_dest,
        output inport_granted,
        output outport_granted,
        output any_ivc_grant
    );

    modport merge (
        input  ivc_granted,
        input  first_arb_ivc,
        input  granted_dest,
        input  inport_granted,
        input  outport_granted,
        input  any_ivc_grant
    );

endinterface

`default_nettype wire

// ==== swa_pkg.sv ====
`default_nettype none

package swa_pkg;

    import noc_pkg::*;

    // request bundle for one allocation stage
    // built by the merge control, one per stage
    typedef struct packed {
        // vc request masks, already split and masked
        vc_mask_arr_t vc_req;
    } swa_req_t;

endpackage

`default_nettype wire

// ==== noc_pkg.sv ====
`default_nettype none

`include "swa_defines.svh"

package noc_pkg;

    // one bit per vc of a port
    typedef logic [`SWA_V-1:0] vc_mask_t;
    // one bit per router port
    typedef logic [`SWA_P-1:0] port_mask_t;
    // one-hot destination, own port left out
    typedef logic [`SWA_P-2:0] outport_sel_t;

    // per-port arrays, index is the input port
    typedef vc_mask_t [`SWA_P-1:0] vc_mask_arr_t;
    typedef outport_sel_t [`SWA_P-1:0] outport_sel_arr_t;
    // destination of every vc, indexed [port][vc]
    typedef outport_sel_t [`SWA_P-1:0][`SWA_V-1:0] dest_sel_arr_t;

    // own-port-excluded select to real output ports
    function automatic port_mask_t sel_to_port(int own, outport_sel_t sel);
        port_mask_t p;
        p = '0;
        for (int j = 0; j < `SWA_P - 1; j++) begin
            // bits at or above own port shift up by one
            if (j < own) begin
                p[j] = sel[j];
            end else begin
                p[j+1] = sel[j];
            end
        end
        return p;
    endfunction

    // real output ports back to the select seen from port own
    function automatic outport_sel_t port_to_sel(int own, port_mask_t p);
        outport_sel_t s;
        s = '0;
        for (int j = 0; j < `SWA_P - 1; j++) begin
            s[j] = (j < own) ? p[j] : p[j+1];
        end
        return s;
    endfunction

endpackage

`default_nettype wire

// ==== swa_defines.svh ====
`ifndef SWA_DEFINES_SVH
`define SWA_DEFINES_SVH

// router geometry for the switch allocator

// number of router ports, local port included
`define SWA_P 5

// virtual channels per port
`define SWA_V 4

`endif
